//--- verilog/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// datapath and instruction width
`define CPU_WORD_W 16

`define CPU_NUM_REGS 16

// fetch address after reset
`define CPU_RESET_PC 0

// JAL writes its return address here
`define CPU_LINK_REG 15

`endif

//--- verilog/core_pkg.sv
`include "cpu_settings.svh"

package core_pkg;

	typedef logic [`CPU_WORD_W-1:0] word_t;

	typedef logic [$clog2(`CPU_NUM_REGS)-1:0] reg_idx_t;

	// processor status, written by CMP/CMPI only
	typedef struct packed
	{
		logic z;	// equal
		logic l;	// unsigned less
		logic n;	// signed less
	} flags_t;

endpackage

//--- verilog/isa_pkg.sv
package isa_pkg;

	// canonical codes, {instr[15:12], instr[7:4]} of the register forms
	typedef enum logic [7:0]
	{
		OP_AND  = 8'h01,
		OP_OR   = 8'h02,
		OP_XOR  = 8'h03,
		OP_ADD  = 8'h05,
		OP_SUB  = 8'h09,
		OP_CMP  = 8'h0B,
		OP_MOV  = 8'h0D,
		OP_MUL  = 8'h0E,
		OP_LSH  = 8'h84,
		OP_ASHU = 8'h86,
		OP_LUI  = 8'hF0
	} op_t;

	typedef enum logic [2:0]
	{
		CLS_ALU,
		CLS_STORE,
		CLS_LOAD,
		CLS_JCOND,
		CLS_BCOND,
		CLS_JAL,
		CLS_NOP
	} iclass_t;

	// cr16 condition field; codes not listed never take
	typedef enum logic [3:0]
	{
		COND_EQ = 4'b0000,
		COND_NE = 4'b0001,
		COND_GT = 4'b0110,
		COND_LE = 4'b0111,
		COND_LO = 4'b1010,
		COND_HS = 4'b1011,
		COND_LT = 4'b1100,
		COND_GE = 4'b1101,
		COND_UC = 4'b1110
	} cond_t;

	typedef struct packed
	{
		iclass_t cls;
		op_t op;
		core_pkg::reg_idx_t rd;
		core_pkg::reg_idx_t rs;
		logic use_imm;
		core_pkg::word_t imm;
		cond_t cond;
		logic writes_rd;
		logic sets_flags;
	} decoded_t;

endpackage

//--- verilog/decoder.sv
`timescale 1ns/1ps

module decoder
(
	input core_pkg::word_t instr,
	output isa_pkg::decoded_t dec
);

	logic [7:0] code;
	logic [3:0] hi_nib;
	core_pkg::word_t imm_sx;
	core_pkg::word_t imm_zx;

	assign hi_nib = instr[15:12];
	assign code = {hi_nib, instr[7:4]};

	// 8-bit immediate field, bits 7..4 and 3..0
	assign imm_sx = {{8{instr[7]}}, instr[7:4], instr[3:0]};
	assign imm_zx = {8'h00, instr[7:4], instr[3:0]};

	always_comb
	begin
		dec.cls = isa_pkg::CLS_NOP;
		dec.op = isa_pkg::OP_MOV;
		dec.rd = instr[11:8];	// data reg for load/store
		dec.rs = instr[3:0];	// address or jump target
		dec.use_imm = 1'b0;
		dec.imm = '0;
		dec.cond = isa_pkg::COND_UC;
		dec.writes_rd = 1'b0;
		dec.sets_flags = 1'b0;

		// exact codes sit ahead of the wildcard forms that overlap them
		case (code) inside
			isa_pkg::OP_AND, isa_pkg::OP_OR, isa_pkg::OP_XOR, isa_pkg::OP_ADD,
			isa_pkg::OP_SUB, isa_pkg::OP_CMP, isa_pkg::OP_MOV, isa_pkg::OP_MUL,
			isa_pkg::OP_LSH, isa_pkg::OP_ASHU:
			begin
				dec.cls = isa_pkg::CLS_ALU;
				dec.op = isa_pkg::op_t'(code);
			end
			8'b0101_????, 8'b1001_????, 8'b1011_????, 8'b1110_????:
			begin
				// ADDI SUBI CMPI MULI
				dec.cls = isa_pkg::CLS_ALU;
				dec.op = isa_pkg::op_t'({4'h0, hi_nib});
				dec.use_imm = 1'b1;
				dec.imm = imm_sx;
			end
			8'b0001_????, 8'b0010_????, 8'b0011_????, 8'b1101_????:
			begin
				// ANDI ORI XORI MOVI
				dec.cls = isa_pkg::CLS_ALU;
				dec.op = isa_pkg::op_t'({4'h0, hi_nib});
				dec.use_imm = 1'b1;
				dec.imm = imm_zx;
			end
			8'b1000_????:
			begin
				dec.cls = isa_pkg::CLS_ALU;	// LSHI, signed amount
				dec.op = isa_pkg::OP_LSH;
				dec.use_imm = 1'b1;
				dec.imm = imm_sx;
			end
			8'b1111_????:
			begin
				dec.cls = isa_pkg::CLS_ALU;
				dec.op = isa_pkg::OP_LUI;	// alu moves it to the upper byte
				dec.use_imm = 1'b1;
				dec.imm = imm_zx;
			end
			8'h40:
			begin
				dec.cls = isa_pkg::CLS_LOAD;
				dec.writes_rd = 1'b1;
			end
			8'h44:
				dec.cls = isa_pkg::CLS_STORE;
			8'h4C:
			begin
				dec.cls = isa_pkg::CLS_JCOND;
				dec.cond = isa_pkg::cond_t'(instr[11:8]);
			end
			8'h48:
			begin
				dec.cls = isa_pkg::CLS_JAL;
				dec.writes_rd = 1'b1;	// link register, picked in the core
			end
			8'b1100_????:
			begin
				dec.cls = isa_pkg::CLS_BCOND;
				dec.cond = isa_pkg::cond_t'(instr[11:8]);
				dec.imm = imm_sx;	// word displacement
			end
			default:
				dec.cls = isa_pkg::CLS_NOP;
		endcase

		// compare only updates the status flags
		if (dec.cls == isa_pkg::CLS_ALU)
		begin
			dec.sets_flags = (dec.op == isa_pkg::OP_CMP);
			dec.writes_rd = (dec.op != isa_pkg::OP_CMP);
		end
	end

	always_comb
	begin
		if (dec.cls inside {isa_pkg::CLS_STORE, isa_pkg::CLS_JCOND, isa_pkg::CLS_BCOND})
			assert (!dec.writes_rd)
			else $error("decoder: register write on a non-writing class");
	end

endmodule

//--- verilog/alu.sv
`timescale 1ns/1ps

module alu
(
	input isa_pkg::op_t op,
	input core_pkg::word_t a,
	input core_pkg::word_t b,
	output core_pkg::word_t result,
	output core_pkg::flags_t flags
);

	logic b_neg;
	core_pkg::word_t b_mag;
	logic [3:0] shamt;

	// shift amount is signed b, magnitude capped at 15
	assign b_neg = b[$bits(b)-1];
	assign b_mag = b_neg ? -b : b;
	assign shamt = (b_mag > 15) ? 4'd15 : b_mag[3:0];

	always_comb
	begin
		case (op)
			isa_pkg::OP_ADD:
				result = a + b;
			isa_pkg::OP_SUB:
				result = a - b;
			isa_pkg::OP_MUL:
				result = a * b;	// low half only
			isa_pkg::OP_AND:
				result = a & b;
			isa_pkg::OP_OR:
				result = a | b;
			isa_pkg::OP_XOR:
				result = a ^ b;
			isa_pkg::OP_MOV:
				result = b;
			isa_pkg::OP_LUI:
				result = b << 8;
			isa_pkg::OP_LSH:
			begin
				if (b_neg)
					result = a >> shamt;
				else
					result = a << shamt;
			end
			isa_pkg::OP_ASHU:
			begin
				if (b_neg)
					result = $signed(a) >>> shamt;
				else
					result = a << shamt;
			end
			isa_pkg::OP_CMP:
				result = a;	// compare leaves rd alone
			default:
				result = a;
		endcase
	end

	// always computed, the pc unit latches them on CMP
	always_comb
	begin
		flags.z = (a == b);
		flags.l = (a < b);
		flags.n = ($signed(a) < $signed(b));
	end

endmodule

//--- verilog/reg_file.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module reg_file
(
	input logic clk,
	input logic rst_n,
	input core_pkg::reg_idx_t ra_idx,
	input core_pkg::reg_idx_t rb_idx,
	output core_pkg::word_t ra_data,
	output core_pkg::word_t rb_data,
	input logic we,
	input core_pkg::reg_idx_t w_idx,
	input core_pkg::word_t w_data
);

	core_pkg::word_t regs [`CPU_NUM_REGS];

	// read through, no bypass needed in a single-cycle core
	assign ra_data = regs[ra_idx];
	assign rb_data = regs[rb_idx];

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < `CPU_NUM_REGS; i++)
				regs[i] <= '0;
		end
		else if (we)
		begin
			regs[w_idx] <= w_data;
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n) we |-> !$isunknown(w_idx))
		else $error("reg_file: write with unknown index");

endmodule

//--- verilog/pc_unit.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module pc_unit
(
	input logic clk,
	input logic rst_n,
	input isa_pkg::decoded_t dec,
	input core_pkg::word_t target,
	input core_pkg::flags_t alu_flags,
	output core_pkg::word_t pc,
	output core_pkg::word_t link
);

	core_pkg::flags_t flags_q;
	logic cond_true;
	core_pkg::word_t pc_next;

	assign link = pc + 1'b1;

	// stored flags, so a compare steers the next instruction
	always_comb
	begin
		case (dec.cond)
			isa_pkg::COND_EQ:
				cond_true = flags_q.z;
			isa_pkg::COND_NE:
				cond_true = !flags_q.z;
			isa_pkg::COND_HS:
				cond_true = !flags_q.l;
			isa_pkg::COND_LO:
				cond_true = flags_q.l;
			isa_pkg::COND_GT:
				cond_true = !(flags_q.n || flags_q.z);
			isa_pkg::COND_LE:
				cond_true = flags_q.n || flags_q.z;
			isa_pkg::COND_LT:
				cond_true = flags_q.n;
			isa_pkg::COND_GE:
				cond_true = !flags_q.n;
			isa_pkg::COND_UC:
				cond_true = 1'b1;
			default:
				cond_true = 1'b0;
		endcase
	end

	always_comb
	begin
		pc_next = link;
		case (dec.cls)
			isa_pkg::CLS_BCOND:
				if (cond_true)
					pc_next = pc + dec.imm;
			isa_pkg::CLS_JCOND, isa_pkg::CLS_JAL:
				if (cond_true)
					pc_next = target;	// JAL carries UC
			default:
				pc_next = link;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pc <= core_pkg::word_t'(`CPU_RESET_PC);
			flags_q <= '0;
		end
		else
		begin
			pc <= pc_next;
			if (dec.sets_flags)
				flags_q <= alu_flags;
		end
	end

endmodule

//--- verilog/cpu_core.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_core
(
	input logic clk,
	input logic rst_n,
	output core_pkg::word_t pc,
	input core_pkg::word_t instr,
	output core_pkg::word_t mem_addr,
	output core_pkg::word_t mem_wdata,
	output logic mem_we,
	input core_pkg::word_t mem_rdata
);

	isa_pkg::decoded_t dec;
	core_pkg::word_t rd_val;
	core_pkg::word_t rs_val;
	core_pkg::word_t alu_b;
	core_pkg::word_t alu_result;
	core_pkg::flags_t alu_flags;
	core_pkg::word_t link;
	core_pkg::reg_idx_t w_idx;
	core_pkg::word_t w_data;

	decoder i_decoder
	(
		.instr(instr),
		.dec(dec)
	);

	reg_file i_reg_file
	(
		.clk(clk),
		.rst_n(rst_n),
		.ra_idx(dec.rd),
		.rb_idx(dec.rs),
		.ra_data(rd_val),
		.rb_data(rs_val),
		.we(dec.writes_rd),
		.w_idx(w_idx),
		.w_data(w_data)
	);

	assign alu_b = dec.use_imm ? dec.imm : rs_val;

	alu i_alu
	(
		.op(dec.op),
		.a(rd_val),
		.b(alu_b),
		.result(alu_result),
		.flags(alu_flags)
	);

	pc_unit i_pc_unit
	(
		.clk(clk),
		.rst_n(rst_n),
		.dec(dec),
		.target(rs_val),
		.alu_flags(alu_flags),
		.pc(pc),
		.link(link)
	);

	// write-back select
	always_comb
	begin
		w_idx = dec.rd;
		case (dec.cls)
			isa_pkg::CLS_LOAD:
				w_data = mem_rdata;
			isa_pkg::CLS_JAL:
			begin
				w_idx = core_pkg::reg_idx_t'(`CPU_LINK_REG);
				w_data = link;
			end
			default:
				w_data = alu_result;
		endcase
	end

	assign mem_addr = rs_val;
	assign mem_wdata = rd_val;
	assign mem_we = (dec.cls == isa_pkg::CLS_STORE) && rst_n;

	assert property (@(posedge clk) !rst_n |-> !mem_we)
		else $error("cpu_core: store strobe during reset");

endmodule

//--- sim/tb_clock.sv
`timescale 1ns/1ps

module tb_clock
(
	output logic clk,
	output logic rst_n
);

	initial
	begin
		clk = 1'b0;
		forever
			#10 clk = ~clk;	// 20 ns period
	end

	// held over four rising edges, let go just after the last one
	initial
	begin
		rst_n = 1'b0;
		repeat (4)
			@(posedge clk);
		#1;
		rst_n = 1'b1;
	end

endmodule

//--- sim/tb_cpu_core.sv
`timescale 1ns/1ps

module tb_cpu_core;

	typedef struct packed
	{
		logic [15:0] instr;
		logic [15:0] rdata;
		logic store;
		logic [15:0] addr;
		logic [15:0] wdata;
		logic [15:0] next_pc;
	} step_t;

	localparam int RESET_TIMEOUT = 20;

	logic clk;
	logic rst_n;
	core_pkg::word_t pc;
	core_pkg::word_t instr;
	core_pkg::word_t mem_addr;
	core_pkg::word_t mem_wdata;
	logic mem_we;
	core_pkg::word_t mem_rdata;

	step_t steps [$];	// executed trace with one row per cycle

	tb_clock i_tb_clock
	(
		.clk(clk),
		.rst_n(rst_n)
	);

	cpu_core i_cpu_core
	(
		.clk(clk),
		.rst_n(rst_n),
		.pc(pc),
		.instr(instr),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_we(mem_we),
		.mem_rdata(mem_rdata)
	);

	task automatic compare(input logic [15:0] actual, input logic [15:0] expected,
		input string what);
		if (actual !== expected)
		begin
			$display("Error at %0t: %s is %h, expected %h", $time, what, actual, expected);
			$display("Test FAILED");
			$fatal(1, "mismatch");
		end
	endtask

	task automatic plain_row(input logic [15:0] code, input logic [15:0] next_pc);
		step_t s;
		s = '0;
		s.instr = code;
		s.next_pc = next_pc;
		steps.push_back(s);
	endtask

	task automatic store_row(input logic [15:0] code, input logic [15:0] addr,
		input logic [15:0] wdata, input logic [15:0] next_pc);
		step_t s;
		s = '0;
		s.instr = code;
		s.store = 1'b1;
		s.addr = addr;
		s.wdata = wdata;
		s.next_pc = next_pc;
		steps.push_back(s);
	endtask

	task automatic load_row(input logic [15:0] code, input logic [15:0] rdata,
		input logic [15:0] next_pc);
		step_t s;
		s = '0;
		s.instr = code;
		s.rdata = rdata;
		s.next_pc = next_pc;
		steps.push_back(s);
	endtask

	task automatic build_program();
		// r2 = 0x40 is the store address
		plain_row(16'hD1F0, 16'd1);	// movi r1 -> 0x00f0
		plain_row(16'h51FD, 16'd2);	// addi -3 -> 0x00ed
		plain_row(16'hD240, 16'd3);
		store_row(16'h4142, 16'h0040, 16'h00ED, 16'd4);
		plain_row(16'h91FE, 16'd5);	// subi -2 -> 0x00ef
		plain_row(16'hE103, 16'd6);	// muli 3 -> 0x02cd
		store_row(16'h4142, 16'h0040, 16'h02CD, 16'd7);
		plain_row(16'hF3A5, 16'd8);	// lui r3
		store_row(16'h4342, 16'h0040, 16'hA500, 16'd9);
		// register-register ops
		plain_row(16'hD40C, 16'd10);
		plain_row(16'hD50A, 16'd11);
		plain_row(16'h0455, 16'd12);	// add r4,r5
		store_row(16'h4442, 16'h0040, 16'h0016, 16'd13);
		plain_row(16'h0493, 16'd14);	// sub r4,r3
		store_row(16'h4442, 16'h0040, 16'h5B16, 16'd15);
		plain_row(16'h0413, 16'd16);	// and
		store_row(16'h4442, 16'h0040, 16'h0100, 16'd17);
		plain_row(16'h0425, 16'd18);	// or
		plain_row(16'h0433, 16'd19);	// xor
		store_row(16'h4442, 16'h0040, 16'hA40A, 16'd20);
		plain_row(16'h05E5, 16'd21);	// mul r5,r5
		store_row(16'h4542, 16'h0040, 16'h0064, 16'd22);
		// shifts by r6 = 3 and r7 = -4
		plain_row(16'hD603, 16'd23);
		plain_row(16'h57FC, 16'd24);
		plain_row(16'h8346, 16'd25);	// lsh left
		store_row(16'h4342, 16'h0040, 16'h2800, 16'd26);
		plain_row(16'hF8A5, 16'd27);
		plain_row(16'h8847, 16'd28);	// lsh right with zero fill
		store_row(16'h4842, 16'h0040, 16'h0A50, 16'd29);
		plain_row(16'hF8A5, 16'd30);
		plain_row(16'h8867, 16'd31);	// ashu right with sign fill
		store_row(16'h4842, 16'h0040, 16'hFA50, 16'd32);
		plain_row(16'h8866, 16'd33);
		store_row(16'h4842, 16'h0040, 16'hD280, 16'd34);
		// load then store back through r9
		plain_row(16'hD980, 16'd35);
		load_row(16'h4A09, 16'h1234, 16'd36);
		store_row(16'h4A49, 16'h0080, 16'h1234, 16'd37);
		// branches and jumps
		plain_row(16'hDB3C, 16'd38);	// r11 = 60
		plain_row(16'h04B4, 16'd39);	// cmp equal
		plain_row(16'hC008, 16'd47);	// beq taken
		plain_row(16'hC103, 16'd48);	// bne not taken
		plain_row(16'hB570, 16'd49);	// 0x64 vs 0x70 sets l and n
		plain_row(16'hCAF7, 16'd40);	// blo backward
		plain_row(16'hC602, 16'd41);	// bgt not taken
		plain_row(16'hCC02, 16'd43);	// blt taken
		plain_row(16'hB5FF, 16'd44);	// 0x64 vs -1 sets only l
		plain_row(16'hC606, 16'd50);	// bgt taken
		plain_row(16'h4CCB, 16'd51);	// jlt not taken
		plain_row(16'h41CB, 16'd60);	// jne to r11
		plain_row(16'hDC64, 16'd61);
		plain_row(16'h408C, 16'd100);	// jal r12
		store_row(16'h4F42, 16'h0040, 16'h003E, 16'd101);	// link = 62
		plain_row(16'h0000, 16'd102);
	endtask

	task automatic wait_reset_release();
		int cycles;
		cycles = 0;
		while (rst_n !== 1'b1)
		begin
			compare({15'd0, mem_we}, 16'd0, "mem_we during reset");
			if (cycles == RESET_TIMEOUT)
			begin
				$display("Reset was not released within %0d cycles", RESET_TIMEOUT);
				$display("Test FAILED");
				$fatal(1, "reset timeout");
			end
			@(posedge clk);
			#2;
			cycles++;
		end
	endtask

	initial
	begin
		$timeformat(-9, 0, " ns", 0);
		instr = 16'h4142;	// store pending while in reset
		mem_rdata = 16'h0000;
		build_program();
		#2;
		wait_reset_release();
		compare(pc, 16'h0000, "pc after reset");
		foreach (steps[i])
		begin
			instr = steps[i].instr;
			mem_rdata = steps[i].rdata;
			#5;
			compare({15'd0, mem_we}, {15'd0, steps[i].store},
				$sformatf("mem_we, step %0d", i));
			if (steps[i].store)
			begin
				compare(mem_addr, steps[i].addr, $sformatf("mem_addr, step %0d", i));
				compare(mem_wdata, steps[i].wdata, $sformatf("mem_wdata, step %0d", i));
			end
			@(posedge clk);
			#2;
			compare(pc, steps[i].next_pc, $sformatf("pc after step %0d", i));
		end
		$display("Test OK");
		$finish;
	end

endmodule

//--- list.f
+incdir+verilog
verilog/core_pkg.sv
verilog/isa_pkg.sv
verilog/decoder.sv
verilog/alu.sv
verilog/reg_file.sv
verilog/pc_unit.sv
verilog/cpu_core.sv
sim/tb_clock.sv
sim/tb_cpu_core.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the cpu_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_cpu_core \
	-Mdir obj_dir -o tb_cpu_core
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/tb_cpu_core > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q "^Test OK$" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1
